//--- build.f
+incdir+verilog
verilog/play_pkg.sv
verilog/song_player.sv
verilog/key_judge.sv
verilog/score_board.sv
verilog/play_mode.sv
verif/play_mode_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the play mode testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
    --top-module play_mode_tb -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vplay_mode_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$log"; then
    exit 0
fi
exit 1

//--- verif/play_mode_tb.sv
// play mode testbench
`timescale 1ns/10ps
`include "play_defines.svh"

module play_mode_tb import play_pkg::*; ();

    localparam int song_notes [2][8] = '{'{1, 2, 3, 4, 5, 6, 7, 0}, '{7, 6, 5, 4, 3, 2, 1, 0}};
    localparam int song_lens  [2][8] = '{'{1, 1, 1, 1, 1, 1, 1, 1}, '{2, 1, 2, 1, 2, 1, 2, 1}};
    localparam int num_tests = 7;
    localparam int test_song  [num_tests] = '{0, 0, 1, 0, 1, 1, 0};
    localparam int test_tempo [num_tests] = '{0, 0, 0, 2, 3, 0, 1};
    localparam int test_user  [num_tests] = '{2, 0, 1, 0, 0, 2, 0};
    localparam int test_mode  [num_tests] = '{0, 1, 1, 2, 2, 2, 2};   // 0 silent, 1 perfect, 2 random
    localparam int test_reset [num_tests] = '{0, 0, 0, 0, 0, 0, 1};

    logic clk = 1'b0;
    logic rst_n, en, song_sel, buzzer, done;
    tempo_t tempo;
    user_t user;
    note_t note_key;
    logic [6:0] note_led;
    disp_t disp;

    logic chk_on, exp_done, exp_tone, buzz_last;
    logic [6:0] exp_led;
    disp_t exp_disp;
    int errors, tests_failed, buzz_run, toggles;
    int first_key [`PLAY_SONG_STEPS];
    int first_off [`PLAY_SONG_STEPS];
    int second_key [`PLAY_SONG_STEPS];
    int second_off [`PLAY_SONG_STEPS];
    disp_t step_disp [`PLAY_SONG_STEPS];              // session totals once each step is scored
    int sess_base, sess_bonus, sess_peak;
    int best_base [`PLAY_NUM_USERS];
    int best_bonus [`PLAY_NUM_USERS];
    int best_combo [`PLAY_NUM_USERS];

    play_mode UUT (
        .clk(clk), .rst_n(rst_n), .en(en), .song_sel(song_sel), .tempo(tempo), .user(user),
        .note_key(note_key), .buzzer(buzzer), .done(done), .note_led(note_led), .disp(disp)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        buzz_last <= buzzer;
        buzz_run  <= (exp_tone && buzzer == buzz_last) ? buzz_run + 1 : 0;
        if (exp_tone && buzzer != buzz_last) begin
            toggles <= toggles + 1;
        end
    end

    a_led: assert property (@(posedge clk) chk_on |-> note_led == exp_led)
        else begin
            errors++;
            $display("mismatch at %0t: note_led %b, expected %b", $time,
                     $sampled(note_led), $sampled(exp_led));
        end
    a_done: assert property (@(posedge clk) chk_on |-> done == exp_done)
        else begin
            errors++;
            $display("mismatch at %0t: done %b, expected %b", $time,
                     $sampled(done), $sampled(exp_done));
        end
    a_quiet: assert property (@(posedge clk) chk_on && !exp_tone |-> !buzzer)
        else begin
            errors++;
            $display("mismatch at %0t: buzzer high with no note", $time);
        end
    a_tone: assert property (@(posedge clk) chk_on && exp_tone |-> buzz_run <= `PLAY_TONE_BASE * 7)
        else begin
            errors++;
            $display("mismatch at %0t: buzzer held %0d cycles", $time, $sampled(buzz_run));
        end
    a_disp: assert property (@(posedge clk) chk_on |-> disp == exp_disp)
        else begin
            errors++;
            $display("mismatch at %0t: disp %h, expected %h", $time,
                     $sampled(disp), $sampled(exp_disp));
        end

    function automatic int step_cycles(input int song, input int tmp, input int i);
        int c;
        c = song_lens[song][i] * `PLAY_UNIT_TICKS;
        if (tmp == 2) c = c * 2;                    // half time
        else if (tmp == 3) c = c / 2;               // double time
        return c;
    endfunction

    function automatic int song_cycles(input int song, input int tmp);
        int total;
        total = 0;
        for (int i = 0; i < `PLAY_SONG_STEPS; i++) total += step_cycles(song, tmp, i);
        return total;
    endfunction

    function automatic logic [6:0] led_of(input int n);
        return (n == 0) ? 7'd0 : 7'd1 << (n - 1);
    endfunction

    // live totals after step k, zero before the first step is scored
    function automatic disp_t totals_after(input int k);
        disp_t d;
        d = '0;
        if (k >= 0) d = step_disp[k];
        return d;
    endfunction

    // any note except g and never a rest
    function automatic int wrong_key(input int g);
        return ((g + $urandom_range(5, 0)) % 7) + 1;
    endfunction

    task automatic plan_keys(input int song, input int tmp, input int mode);
        int g, len, pick;
        for (int i = 0; i < `PLAY_SONG_STEPS; i++) begin
            g = song_notes[song][i];
            len = step_cycles(song, tmp, i);
            first_key[i] = 0;
            second_key[i] = 0;
            first_off[i] = $urandom_range(len / 2 - 1, 0);
            second_off[i] = len - 1;                   // late press on the step's last cycle
            pick = (mode == 2) ? $urandom_range(3, 0) : ((mode == 1) ? 0 : 2);
            if (g == 0) begin
                if (pick == 1) first_key[i] = $urandom_range(7, 1);
            end else if (pick == 0 || pick == 3) begin
                first_key[i] = g;
                if (pick == 3) second_key[i] = wrong_key(g);
            end else if (pick == 1) begin
                first_key[i] = wrong_key(g);
                second_key[i] = g;
            end
        end
    endtask

    // scoring rules applied to the first press of each step
    task automatic score_session(input int song, input int usr);
        int g, combo;
        bit hit;
        sess_base = 0;
        sess_bonus = 0;
        sess_peak = 0;
        combo = 0;
        for (int i = 0; i < `PLAY_SONG_STEPS; i++) begin
            g = song_notes[song][i];
            hit = (g != 0) ? (first_key[i] == g) : (first_key[i] == 0);
            if (hit) begin
                if (g != 0) sess_base += 2;
                if (combo >= `PLAY_COMBO_BONUS_MIN) sess_bonus += 1;
                combo++;
            end else begin
                combo = 0;
            end
            if (combo > sess_peak) sess_peak = combo;
            step_disp[i] = {score_t'(sess_base), score_t'(sess_bonus), score_t'(sess_peak)};
        end
        if (sess_base > best_base[usr]) best_base[usr] = sess_base;
        if (sess_bonus > best_bonus[usr]) best_bonus[usr] = sess_bonus;
        if (sess_peak > best_combo[usr]) best_combo[usr] = sess_peak;
    endtask

    task automatic play_session(input int song, input int tmp, input int usr, input int mode);
        int len, i, j, tog_start;
        plan_keys(song, tmp, mode);
        score_session(song, usr);
        @(posedge clk);
        song_sel <= (song == 1);
        tempo <= tempo_t'(tmp);
        user <= user_t'(usr);
        @(posedge clk);
        en <= 1'b1;
        tog_start = toggles;
        for (i = 0; i < `PLAY_SONG_STEPS; i++) begin
            len = step_cycles(song, tmp, i);
            for (j = 0; j < len; j++) begin
                @(posedge clk);
                exp_led <= led_of(song_notes[song][i]);
                exp_tone <= (song_notes[song][i] != 0);
                // totals trail a step end by two cycles
                exp_disp <= totals_after((j == 0) ? i - 2 : i - 1);
                if (j == first_off[i]) note_key <= note_t'(first_key[i]);
                else if (j == second_off[i]) note_key <= note_t'(second_key[i]);
                else note_key <= '0;
            end
        end
        @(posedge clk);
        note_key <= '0;
        exp_led <= '0;
        exp_tone <= 1'b0;
        exp_done <= 1'b1;
        exp_disp <= totals_after(`PLAY_SONG_STEPS - 2);
        while (!done) @(negedge clk);
        @(posedge clk);
        // best view from here on
        exp_disp <= {score_t'(best_base[usr]), score_t'(best_bonus[usr]), score_t'(best_combo[usr])};
        assert (toggles != tog_start)
            else begin
                errors++;
                $display("buzzer never toggled during the song at %0t", $time);
            end
        repeat (3) @(posedge clk);
        en <= 1'b0;
        @(posedge clk);
        exp_done <= 1'b0;
        exp_disp <= '0;
        repeat (3) @(posedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int u = 0; u < `PLAY_NUM_USERS; u++) begin
            best_base[u] = 0;
            best_bonus[u] = 0;
            best_combo[u] = 0;
        end
    endtask

    initial begin : watchdog
        int limit;
        limit = 100;
        for (int t = 0; t < num_tests; t++) begin
            limit += song_cycles(test_song[t], test_tempo[t]) * 2 + 40;
        end
        #(limit * 10);
        $display("watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int errs_before;
        void'($urandom(32'h80d5e825));
        rst_n = 1'b0;
        en = 1'b0;
        song_sel = 1'b0;
        tempo = '0;
        user = '0;
        note_key = '0;
        chk_on = 1'b0;
        exp_done = 1'b0;
        exp_tone = 1'b0;
        exp_led = '0;
        exp_disp = '0;
        buzz_last = 1'b0;
        errors = 0;
        tests_failed = 0;
        buzz_run = 0;
        toggles = 0;
        apply_reset();
        @(posedge clk);
        chk_on <= 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            if (test_reset[t] != 0) apply_reset();
            errs_before = errors;
            play_session(test_song[t], test_tempo[t], test_user[t], test_mode[t]);
            if (errors == errs_before) begin
                $display("test %0d song %0d tempo %0d user %0d mode %0d: ok", t + 1,
                         test_song[t], test_tempo[t], test_user[t], test_mode[t]);
            end else begin
                tests_failed++;
                $display("test %0d song %0d tempo %0d user %0d mode %0d: failed with %0d errors",
                         t + 1, test_song[t], test_tempo[t], test_user[t], test_mode[t],
                         errors - errs_before);
            end
        end
        $display("tests run %0d, tests failed %0d, errors %0d", num_tests, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/key_judge.sv
// note key judge
`timescale 1ns/10ps
`include "play_defines.svh"

module key_judge import play_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  song_step_t goal,
    input  logic       step_start,
    input  logic       step_end,
    input  note_t      note_key,
    output judge_t     judgement
);

    note_t  key_q;          // first key of the current step
    logic   key_seen;
    note_t  cap_key;
    logic   cap_seen;
    note_t  eff_key;
    logic   eff_seen;
    logic   hit;
    logic   bonus;
    score_t combo_q;
    score_t combo_nxt;

    always_comb begin
        // a new step forgets the previous capture
        cap_seen = step_start ? 1'b0 : key_seen;
        cap_key  = step_start ? note_t'(0) : key_q;

        if (!cap_seen && (note_key != '0)) begin
            eff_seen = 1'b1;
            eff_key  = note_key;
        end else begin
            eff_seen = cap_seen;                        // later presses ignored
            eff_key  = cap_key;
        end

        if (goal.note != '0) begin
            hit = eff_seen && (eff_key == goal.note);
        end else begin
            hit = !eff_seen;                            // rest needs silence
        end

        bonus     = hit && (combo_q >= score_t'(`PLAY_COMBO_BONUS_MIN));
        combo_nxt = hit ? combo_q + 1'b1 : '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            key_q    <= '0;
            key_seen <= 1'b0;
            combo_q  <= '0;
        end else begin
            key_q    <= eff_key;
            key_seen <= eff_seen;
            if (step_end) begin
                combo_q <= combo_nxt;
            end
        end
    end

    // one-cycle result after each step end
    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            judgement <= '0;
        end else if (step_end) begin
            judgement.valid     <= 1'b1;
            judgement.hit       <= hit;
            judgement.base_pts  <= (hit && (goal.note != '0)) ? 2'd2 : 2'd0;
            judgement.bonus_pts <= bonus;
            judgement.combo     <= combo_nxt;
        end else begin
            judgement <= '0;
        end
    end

endmodule

//--- verilog/play_defines.svh
// play mode constants
`ifndef PLAY_DEFINES_SVH
`define PLAY_DEFINES_SVH

// clock cycles per length unit at normal tempo
`define PLAY_UNIT_TICKS 8

// steps in every built-in song
`define PLAY_SONG_STEPS 8

// user slots in the best table
`define PLAY_NUM_USERS 4

// combo count from which a hit earns a bonus point
`define PLAY_COMBO_BONUS_MIN 4

// tone half-period base in cycles
`define PLAY_TONE_BASE 2

`define PLAY_TICK_W 6
`define PLAY_TONE_W 5

`define PLAY_TEMPO_HALF 2'b10
`define PLAY_TEMPO_DOUBLE 2'b11

`endif

//--- verilog/play_mode.sv
// rhythm game play mode
`timescale 1ns/10ps

module play_mode import play_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       song_sel,
    input  tempo_t     tempo,
    input  user_t      user,
    input  note_t      note_key,
    output logic       buzzer,
    output logic       done,
    output logic [6:0] note_led,
    output disp_t      disp
);

    song_step_t goal;
    logic       step_start;
    logic       step_end;
    judge_t     judgement;

    song_player u_player (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .song_sel   (song_sel),
        .tempo      (tempo),
        .goal       (goal),
        .step_start (step_start),
        .step_end   (step_end),
        .done       (done),
        .buzzer     (buzzer)
    );

    key_judge u_judge (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .goal       (goal),
        .step_start (step_start),
        .step_end   (step_end),
        .note_key   (note_key),
        .judgement  (judgement)
    );

    score_board u_board (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .user       (user),
        .judgement  (judgement),
        .done       (done),
        .disp       (disp)
    );

    // goal is zero when idle or done, so the LEDs go dark there
    always_comb begin
        note_led = '0;
        if (goal.note != '0) begin
            note_led[goal.note - 3'd1] = 1'b1;          // note n on bit n-1
        end
    end

endmodule

//--- verilog/play_pkg.sv
// play mode types
package play_pkg;

    typedef logic [2:0] note_t;          // 0 rest or no key, 1..7 do..ti
    typedef logic [1:0] len_t;           // step length in units
    typedef logic [1:0] tempo_t;         // 10 half time, 11 double time
    typedef logic [3:0] step_idx_t;
    typedef logic [1:0] user_t;
    typedef logic [15:0] score_t;

    // one song ROM entry
    typedef struct packed {
        note_t note;
        len_t  len;
    } song_step_t;

    // result of one step, valid for a single cycle
    typedef struct packed {
        logic       valid;
        logic       hit;
        logic [1:0] base_pts;
        logic       bonus_pts;
        score_t     combo;           // combo after this step
    } judge_t;

    typedef struct packed {
        score_t base;
        score_t bonus;
        score_t combo;
    } disp_t;

    typedef enum logic [1:0] {
        IDLE,
        PLAY,
        DONE
    } player_state_t;

endpackage

//--- verilog/score_board.sv
// session scores and best table
`timescale 1ns/10ps
`include "play_defines.svh"

module score_board import play_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   en,
    input  user_t  user,
    input  judge_t judgement,
    input  logic   done,
    output disp_t  disp
);

    disp_t sess_q;                              // combo field holds the session peak
    disp_t sess_nxt;
    disp_t best_tbl [`PLAY_NUM_USERS];
    disp_t best_cur;
    logic  done_q;
    logic  commit;

    function automatic score_t max_score(input score_t a, input score_t b);
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        sess_nxt = sess_q;
        if (judgement.valid) begin
            sess_nxt.base  = sess_q.base + score_t'(judgement.base_pts);
            sess_nxt.bonus = sess_q.bonus + score_t'(judgement.bonus_pts);
            sess_nxt.combo = max_score(sess_q.combo, judgement.combo);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            sess_q <= '0;
            done_q <= 1'b0;
        end else begin
            sess_q <= sess_nxt;
            done_q <= done;
        end
    end

    // the last judgement arrives together with done, so fold in sess_nxt
    assign commit   = en && done && !done_q;
    assign best_cur = best_tbl[user];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `PLAY_NUM_USERS; i++) begin
                best_tbl[i] <= '0;
            end
        end else if (commit) begin
            best_tbl[user].base  <= max_score(best_cur.base, sess_nxt.base);
            best_tbl[user].bonus <= max_score(best_cur.bonus, sess_nxt.bonus);
            best_tbl[user].combo <= max_score(best_cur.combo, sess_nxt.combo);
        end
    end

    // best view from the cycle after the commit
    assign disp = done_q ? best_cur : sess_q;

endmodule

//--- verilog/song_player.sv
// song sequencer and buzzer
`timescale 1ns/10ps
`include "play_defines.svh"

module song_player import play_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       song_sel,
    input  tempo_t     tempo,
    output song_step_t goal,
    output logic       step_start,
    output logic       step_end,
    output logic       done,
    output logic       buzzer
);

    player_state_t state;
    step_idx_t     idx;
    logic          song_q;                      // latched while idle
    tempo_t        tempo_q;
    song_step_t    rom_step;
    logic [`PLAY_TICK_W-1:0] tick;
    logic [`PLAY_TICK_W-1:0] base_ticks;
    logic [`PLAY_TICK_W-1:0] step_ticks;
    logic [`PLAY_TONE_W-1:0] tone_cnt;
    logic [`PLAY_TONE_W-1:0] tone_half;
    logic          tone_on;
    logic          buzz_q;

    // both songs, indexed by {song, step}
    always_comb begin
        rom_step = '{note: 3'd0, len: 2'd1};
        case ({song_q, idx})
            5'h00: rom_step = '{note: 3'd1, len: 2'd1};
            5'h01: rom_step = '{note: 3'd2, len: 2'd1};
            5'h02: rom_step = '{note: 3'd3, len: 2'd1};
            5'h03: rom_step = '{note: 3'd4, len: 2'd1};
            5'h04: rom_step = '{note: 3'd5, len: 2'd1};
            5'h05: rom_step = '{note: 3'd6, len: 2'd1};
            5'h06: rom_step = '{note: 3'd7, len: 2'd1};
            5'h07: rom_step = '{note: 3'd0, len: 2'd1};
            5'h10: rom_step = '{note: 3'd7, len: 2'd2};
            5'h11: rom_step = '{note: 3'd6, len: 2'd1};
            5'h12: rom_step = '{note: 3'd5, len: 2'd2};
            5'h13: rom_step = '{note: 3'd4, len: 2'd1};
            5'h14: rom_step = '{note: 3'd3, len: 2'd2};
            5'h15: rom_step = '{note: 3'd2, len: 2'd1};
            5'h16: rom_step = '{note: 3'd1, len: 2'd2};
            5'h17: rom_step = '{note: 3'd0, len: 2'd1};
            default: rom_step = '{note: 3'd0, len: 2'd1};
        endcase
    end

    // step duration with tempo scaling
    always_comb begin
        base_ticks = `PLAY_TICK_W'(rom_step.len) * `PLAY_TICK_W'(`PLAY_UNIT_TICKS);
        case (tempo_q)
            `PLAY_TEMPO_HALF:   step_ticks = base_ticks << 1;
            `PLAY_TEMPO_DOUBLE: step_ticks = base_ticks >> 1;
            default:            step_ticks = base_ticks;
        endcase
    end

    assign step_start = (state == PLAY) && (tick == '0);
    assign step_end   = (state == PLAY) && (tick == step_ticks - 1'b1);
    assign done       = (state == DONE);
    assign goal       = (state == PLAY) ? rom_step : '0;   // nothing outside a song

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            idx     <= '0;
            tick    <= '0;
            song_q  <= 1'b0;
            tempo_q <= '0;
        end else if (!en) begin
            state   <= IDLE;
            idx     <= '0;
            tick    <= '0;
            song_q  <= song_sel;
            tempo_q <= tempo;
        end else begin
            case (state)
                IDLE: begin
                    state <= PLAY;                      // step 0 starts next cycle
                    idx   <= '0;
                    tick  <= '0;
                end
                PLAY: begin
                    if (step_end) begin
                        tick <= '0;
                        if (idx == step_idx_t'(`PLAY_SONG_STEPS - 1)) begin
                            state <= DONE;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: state <= DONE;                 // hold until en falls
            endcase
        end
    end

    // square wave, pitch rises with the note number
    assign tone_on   = (state == PLAY) && (rom_step.note != '0);
    assign tone_half = `PLAY_TONE_W'(`PLAY_TONE_BASE * (8 - int'(rom_step.note)));

    always_ff @(posedge clk) begin
        if (!rst_n || !tone_on) begin
            tone_cnt <= '0;
            buzz_q   <= 1'b0;
        end else if (tone_cnt >= tone_half - 1'b1) begin
            tone_cnt <= '0;
            buzz_q   <= ~buzz_q;
        end else begin
            tone_cnt <= tone_cnt + 1'b1;
        end
    end

    assign buzzer = tone_on & buzz_q;

endmodule
